// ==== hw/axi_lite_pkg.sv ====
package axi_lite_pkg;

    // bus widths
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    typedef logic [AXI_DATA_W-1:0] axi_data_t;

    // word index, address bits 9:2
    typedef logic [7:0] reg_addr_t;

    // address bits 11:10 select the register bank
    localparam logic [1:0] REG_BANK_SEL = 2'b00;
    localparam logic [1:0] RESP_OKAY    = 2'b00;

    // register word indices
    localparam reg_addr_t REG_CTRL     = 8'd0;
    localparam reg_addr_t REG_ITEM_NUM = 8'd1;

endpackage

// ==== hw/hd_pkg.sv ====
package hd_pkg;

    // ======================================================================
    // hypervector geometry
    // ======================================================================
    localparam int DIM    = 128;
    localparam int WORD_W = 32;
    localparam int BEAT_W = 64;
    localparam int BEAT_STRB_W = BEAT_W / 8;

    // prng words per vector, stream beats per vector
    localparam int WORDS_PER_VEC = DIM / WORD_W;
    localparam int BEATS_PER_VEC = DIM / BEAT_W;

    typedef logic [DIM-1:0]    hv_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BEAT_W-1:0] beat_t;
    typedef logic [15:0]       item_idx_t;
    typedef logic [1:0]        word_idx_t;
    typedef logic [0:0]        beat_idx_t;

    // ======================================================================
    // xorshift32 constants
    // ======================================================================
    localparam word_t XS_SEED    = 32'h9e37_79b9;
    localparam int    XS_SHIFT_A = 13;
    localparam int    XS_SHIFT_B = 17;
    localparam int    XS_SHIFT_C = 5;

    // every byte of a beat is valid
    localparam logic [BEAT_STRB_W-1:0] STRB_ALL = 8'hff;

endpackage

// ==== hw/axi_lite_slave.sv ====
`timescale 1ns/1ps

module axi_lite_slave (
    input  logic                                 AXIS_ACLK,
    input  logic                                 S_AXI_ARESETN,
    input  logic [axi_lite_pkg::AXI_ADDR_W-1:0]  S_AXI_AWADDR,
    input  logic                                 S_AXI_AWVALID,
    output logic                                 S_AXI_AWREADY,
    input  axi_lite_pkg::axi_data_t              S_AXI_WDATA,
    input  logic [axi_lite_pkg::AXI_STRB_W-1:0]  S_AXI_WSTRB,
    input  logic                                 S_AXI_WVALID,
    output logic                                 S_AXI_WREADY,
    output logic [1:0]                           S_AXI_BRESP,
    output logic                                 S_AXI_BVALID,
    input  logic                                 S_AXI_BREADY,
    input  logic [axi_lite_pkg::AXI_ADDR_W-1:0]  S_AXI_ARADDR,
    input  logic                                 S_AXI_ARVALID,
    output logic                                 S_AXI_ARREADY,
    output axi_lite_pkg::axi_data_t              S_AXI_RDATA,
    output logic [1:0]                           S_AXI_RRESP,
    output logic                                 S_AXI_RVALID,
    input  logic                                 S_AXI_RREADY,
    output logic                                 wr_en,
    output axi_lite_pkg::reg_addr_t              wr_addr,
    output axi_lite_pkg::axi_data_t              wr_data,
    output logic                                 rd_en,
    output axi_lite_pkg::reg_addr_t              rd_addr,
    input  axi_lite_pkg::axi_data_t              rd_data
);

    typedef enum logic [2:0] {
        st_idle,
        st_addr_seen,
        st_data_seen,
        st_write_resp,
        st_read_decode,
        st_read_resp
    } state_t;

    state_t state;

    // latched address bits, bank in 11:10
    logic [11:2] awaddr_q;
    logic [11:2] araddr_q;
    axi_lite_pkg::axi_data_t wdata_q;
    logic [axi_lite_pkg::AXI_STRB_W-1:0] wstrb_q;

    logic aw_take;
    logic w_take;
    logic wr_fire;
    logic [11:2] wr_addr_cur;
    logic [axi_lite_pkg::AXI_STRB_W-1:0] wstrb_cur;
    logic rd_bank_ok;

    // ======================================================================
    // handshake outputs
    // ======================================================================
    assign S_AXI_AWREADY = (state == st_idle) || (state == st_data_seen);
    assign S_AXI_WREADY  = (state == st_idle) || (state == st_addr_seen);
    // a pending write wins over a read in idle
    assign S_AXI_ARREADY = (state == st_idle) && !S_AXI_AWVALID && !S_AXI_WVALID;
    assign S_AXI_BVALID  = (state == st_write_resp);
    assign S_AXI_RVALID  = (state == st_read_resp);
    assign S_AXI_BRESP   = axi_lite_pkg::RESP_OKAY;
    assign S_AXI_RRESP   = axi_lite_pkg::RESP_OKAY;

    assign aw_take = S_AXI_AWVALID && S_AXI_AWREADY;
    assign w_take  = S_AXI_WVALID && S_AXI_WREADY;

    // last half of the write arrives this cycle
    assign wr_fire = ((state == st_idle) && S_AXI_AWVALID && S_AXI_WVALID)
                  || ((state == st_addr_seen) && S_AXI_WVALID)
                  || ((state == st_data_seen) && S_AXI_AWVALID);

    // take the live bus value when it is accepted now
    assign wr_addr_cur = aw_take ? S_AXI_AWADDR[11:2] : awaddr_q;
    assign wr_data     = w_take ? S_AXI_WDATA : wdata_q;
    assign wstrb_cur   = w_take ? S_AXI_WSTRB : wstrb_q;

    // strobe lands on the edge into write_resp
    // no byte lanes means no update
    assign wr_en   = wr_fire && (wr_addr_cur[11:10] == axi_lite_pkg::REG_BANK_SEL)
                  && (|wstrb_cur);
    assign wr_addr = wr_addr_cur[9:2];

    assign rd_bank_ok = (araddr_q[11:10] == axi_lite_pkg::REG_BANK_SEL);
    assign rd_en      = (state == st_read_decode) && rd_bank_ok;
    assign rd_addr    = araddr_q[9:2];

    // out-of-bank reads return zero
    assign S_AXI_RDATA = rd_bank_ok ? rd_data : '0;

    // ======================================================================
    // state machine
    // ======================================================================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (S_AXI_AWVALID && S_AXI_WVALID) begin
                        state <= st_write_resp;
                    end else if (S_AXI_AWVALID) begin
                        state <= st_addr_seen;
                    end else if (S_AXI_WVALID) begin
                        state <= st_data_seen;
                    end else if (S_AXI_ARVALID) begin
                        state <= st_read_decode;
                    end
                end
                st_addr_seen: begin
                    if (S_AXI_WVALID) begin
                        state <= st_write_resp;
                    end
                end
                st_data_seen: begin
                    if (S_AXI_AWVALID) begin
                        state <= st_write_resp;
                    end
                end
                st_write_resp: begin
                    if (S_AXI_BREADY) begin
                        state <= st_idle;
                    end
                end
                // register file fetches here
                st_read_decode: state <= st_read_resp;
                st_read_resp: begin
                    if (S_AXI_RREADY) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // address and data capture
    always_ff @(posedge AXIS_ACLK) begin
        if (aw_take) begin
            awaddr_q <= S_AXI_AWADDR[11:2];
        end
        if (w_take) begin
            wdata_q <= S_AXI_WDATA;
            wstrb_q <= S_AXI_WSTRB;
        end
        if (S_AXI_ARVALID && S_AXI_ARREADY) begin
            araddr_q <= S_AXI_ARADDR[11:2];
        end
    end

    // one response channel at a time
    a_one_resp: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(S_AXI_BVALID && S_AXI_RVALID));

endmodule

// ==== hw/ctrl_regs.sv ====
`timescale 1ns/1ps

module ctrl_regs (
    input  logic                     AXIS_ACLK,
    input  logic                     S_AXI_ARESETN,
    input  logic                     wr_en,
    input  axi_lite_pkg::reg_addr_t  wr_addr,
    input  axi_lite_pkg::axi_data_t  wr_data,
    input  logic                     rd_en,
    input  axi_lite_pkg::reg_addr_t  rd_addr,
    input  logic                     item_done,
    input  logic                     stream_done,
    output axi_lite_pkg::axi_data_t  rd_data,
    output logic                     gen,
    output hd_pkg::item_idx_t        item_num,
    output logic                     stream_go
);

    logic run;
    logic ctrl_wr;

    assign ctrl_wr = wr_en && (wr_addr == axi_lite_pkg::REG_CTRL);

    // streaming waits until generation has finished
    assign stream_go = run && !gen;

    // ======================================================================
    // register writes
    // ======================================================================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            run      <= 1'b0;
            gen      <= 1'b0;
            item_num <= '0;
        end else begin
            // bus write beats the self-clear
            if (ctrl_wr) begin
                run <= wr_data[1];
                gen <= wr_data[0];
            end else begin
                if (item_done) begin
                    gen <= 1'b0;
                end
                if (stream_done) begin
                    run <= 1'b0;
                end
            end
            if (wr_en && (wr_addr == axi_lite_pkg::REG_ITEM_NUM)) begin
                item_num <= wr_data[15:0];
            end
        end
    end

    // read mux, held until the next read
    always_ff @(posedge AXIS_ACLK) begin
        if (rd_en) begin
            rd_data <= '0;
            case (rd_addr)
                axi_lite_pkg::REG_CTRL:     rd_data[1:0]  <= {run, gen};
                axi_lite_pkg::REG_ITEM_NUM: rd_data[15:0] <= item_num;
                default:                    rd_data       <= '0;
            endcase
        end
    end

    // generator only finishes a run that was started
    a_done_in_gen: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        item_done |-> gen);

endmodule

// ==== hw/xorshift32.sv ====
`timescale 1ns/1ps

module xorshift32 (
    input  logic          AXIS_ACLK,
    input  logic          enable,
    output hd_pkg::word_t rand_word
);

    hd_pkg::word_t state;
    hd_pkg::word_t next_state;

    // three shift/xor stages
    always_comb begin
        next_state = state;
        next_state = next_state ^ (next_state << hd_pkg::XS_SHIFT_A);
        next_state = next_state ^ (next_state >> hd_pkg::XS_SHIFT_B);
        next_state = next_state ^ (next_state << hd_pkg::XS_SHIFT_C);
    end

    // seed reload while idle
    always_ff @(posedge AXIS_ACLK) begin
        if (!enable) begin
            state <= hd_pkg::XS_SEED;
        end else begin
            state <= next_state;
        end
    end

    // first enabled word is one step past the seed
    assign rand_word = next_state;

    // zero is a fixed point of xorshift
    a_not_zero: assert property (@(posedge AXIS_ACLK) enable |-> (state != '0));

endmodule

// ==== hw/item_memory_gen.sv ====
`timescale 1ns/1ps

module item_memory_gen (
    input  logic              AXIS_ACLK,
    input  logic              S_AXI_ARESETN,
    input  logic              gen,
    input  hd_pkg::item_idx_t item_num,
    output logic              item_done,
    output hd_pkg::hv_t       captured
);

    hd_pkg::word_t     rand_word;
    hd_pkg::word_idx_t word_idx;
    hd_pkg::item_idx_t item_idx;
    hd_pkg::hv_t       assembly;
    hd_pkg::hv_t       next_vec;
    logic              last_slot;
    logic              hit;

    xorshift32 prng_i (
        .AXIS_ACLK (AXIS_ACLK),
        .enable    (gen),
        .rand_word (rand_word)
    );

    // ======================================================================
    // vector assembly
    // ======================================================================
    // word j goes to bits 32j+31:32j
    always_comb begin
        next_vec = assembly;
        next_vec[word_idx*hd_pkg::WORD_W +: hd_pkg::WORD_W] = rand_word;
    end

    assign last_slot = (word_idx == hd_pkg::word_idx_t'(hd_pkg::WORDS_PER_VEC - 1));
    // selected item completes this cycle
    assign hit = gen && last_slot && (item_idx == item_num);

    // slot and item counters
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            word_idx <= '0;
            item_idx <= '0;
        end else begin
            word_idx <= word_idx + 1'b1;
            if (last_slot) begin
                item_idx <= item_idx + 1'b1;
            end
        end
    end

    // every slot is rewritten per item
    always_ff @(posedge AXIS_ACLK) begin
        if (gen) begin
            assembly <= next_vec;
        end
    end

    // keep only the selected vector
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            captured  <= '0;
            item_done <= 1'b0;
        end else begin
            item_done <= hit;
            if (hit) begin
                captured <= next_vec;
            end
        end
    end

endmodule

// ==== hw/stream_out.sv ====
`timescale 1ns/1ps

module stream_out (
    input  logic                                AXIS_ACLK,
    input  logic                                S_AXI_ARESETN,
    input  logic                                stream_go,
    input  hd_pkg::hv_t                         captured,
    output logic                                stream_done,
    output logic                                M_AXIS_TVALID,
    output hd_pkg::beat_t                       M_AXIS_TDATA,
    output logic [hd_pkg::BEAT_STRB_W-1:0]      M_AXIS_TSTRB,
    output logic                                M_AXIS_TLAST,
    input  logic                                M_AXIS_TREADY
);

    logic              busy;
    hd_pkg::beat_idx_t beat_idx;
    logic              last_beat;

    assign last_beat = (beat_idx == hd_pkg::beat_idx_t'(hd_pkg::BEATS_PER_VEC - 1));

    // beat b is bits 64b+63:64b
    assign M_AXIS_TVALID = busy;
    assign M_AXIS_TDATA  = captured[beat_idx*hd_pkg::BEAT_W +: hd_pkg::BEAT_W];
    assign M_AXIS_TSTRB  = hd_pkg::STRB_ALL;
    assign M_AXIS_TLAST  = busy && last_beat;
    // last beat accepted
    assign stream_done   = M_AXIS_TVALID && M_AXIS_TREADY && M_AXIS_TLAST;

    // beat counter, advances per handshake
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            busy     <= 1'b0;
            beat_idx <= '0;
        end else if (!busy) begin
            if (stream_go) begin
                busy     <= 1'b1;
                beat_idx <= '0;
            end
        end else if (M_AXIS_TREADY) begin
            if (last_beat) begin
                busy <= 1'b0;
            end
            beat_idx <= beat_idx + 1'b1;
        end
    end

    // AXI-Stream hold rule under back-pressure
    a_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (M_AXIS_TVALID && !M_AXIS_TREADY) |=> (M_AXIS_TVALID && $stable(M_AXIS_TDATA)));

endmodule

// ==== hw/hd_top.sv ====
`timescale 1ns/1ps

module hd_top (
    input  logic                                 AXIS_ACLK,
    input  logic                                 S_AXI_ARESETN,
    input  logic [axi_lite_pkg::AXI_ADDR_W-1:0]  S_AXI_AWADDR,
    input  logic                                 S_AXI_AWVALID,
    output logic                                 S_AXI_AWREADY,
    input  axi_lite_pkg::axi_data_t              S_AXI_WDATA,
    input  logic [axi_lite_pkg::AXI_STRB_W-1:0]  S_AXI_WSTRB,
    input  logic                                 S_AXI_WVALID,
    output logic                                 S_AXI_WREADY,
    output logic [1:0]                           S_AXI_BRESP,
    output logic                                 S_AXI_BVALID,
    input  logic                                 S_AXI_BREADY,
    input  logic [axi_lite_pkg::AXI_ADDR_W-1:0]  S_AXI_ARADDR,
    input  logic                                 S_AXI_ARVALID,
    output logic                                 S_AXI_ARREADY,
    output axi_lite_pkg::axi_data_t              S_AXI_RDATA,
    output logic [1:0]                           S_AXI_RRESP,
    output logic                                 S_AXI_RVALID,
    input  logic                                 S_AXI_RREADY,
    output logic                                 M_AXIS_TVALID,
    output hd_pkg::beat_t                        M_AXIS_TDATA,
    output logic [hd_pkg::BEAT_STRB_W-1:0]       M_AXIS_TSTRB,
    output logic                                 M_AXIS_TLAST,
    input  logic                                 M_AXIS_TREADY
);

    // register strobes
    logic                    wr_en;
    axi_lite_pkg::reg_addr_t wr_addr;
    axi_lite_pkg::axi_data_t wr_data;
    logic                    rd_en;
    axi_lite_pkg::reg_addr_t rd_addr;
    axi_lite_pkg::axi_data_t rd_data;

    // control and result
    logic              gen;
    hd_pkg::item_idx_t item_num;
    logic              stream_go;
    logic              item_done;
    logic              stream_done;
    hd_pkg::hv_t       captured;

    // ======================================================================
    // bus side
    // ======================================================================
    axi_lite_slave axi_lite_slave_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WSTRB   (S_AXI_WSTRB),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    ctrl_regs ctrl_regs_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .item_done     (item_done),
        .stream_done   (stream_done),
        .rd_data       (rd_data),
        .gen           (gen),
        .item_num      (item_num),
        .stream_go     (stream_go)
    );

    // ======================================================================
    // generator and streamer
    // ======================================================================
    item_memory_gen item_memory_gen_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_num      (item_num),
        .item_done     (item_done),
        .captured      (captured)
    );

    stream_out stream_out_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .stream_go     (stream_go),
        .captured      (captured),
        .stream_done   (stream_done),
        .M_AXIS_TVALID (M_AXIS_TVALID),
        .M_AXIS_TDATA  (M_AXIS_TDATA),
        .M_AXIS_TSTRB  (M_AXIS_TSTRB),
        .M_AXIS_TLAST  (M_AXIS_TLAST),
        .M_AXIS_TREADY (M_AXIS_TREADY)
    );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic AXIS_ACLK,
    output logic S_AXI_ARESETN
);

    // 100 ns period
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    initial begin
        AXIS_ACLK = 1'b0;
        forever #(HALF_PERIOD) AXIS_ACLK = ~AXIS_ACLK;
    end

    // reset low over the first four rising edges
    initial begin
        S_AXI_ARESETN = 1'b0;
        repeat (RESET_CYCLES) @(posedge AXIS_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;
    end

endmodule

// ==== testbench/tb_hd_top.sv ====
`timescale 1ns/1ps

module tb_hd_top;

    localparam int NUM_ROWS  = 5;
    localparam int BEATS     = hd_pkg::BEATS_PER_VEC;
    localparam int HS_LIMIT  = 16;
    localparam int DRIVE_DLY = 1;
    // register byte offsets
    localparam logic [31:0] ADDR_CTRL     = 32'h0000_0000;
    localparam logic [31:0] ADDR_ITEM_NUM = 32'h0000_0004;
    localparam logic [31:0] ADDR_EVEN     = 32'h0000_0008;
    localparam logic [31:0] ADDR_OFF_BANK = 32'h0000_0404;

    logic AXIS_ACLK;
    logic S_AXI_ARESETN;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0] wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;
    logic tvalid, tready, tlast;
    logic [63:0] tdata;
    logic [7:0] tstrb;

    // stimulus and expected table
    int          row_n [NUM_ROWS] = '{0, 1, 5, 37, 300};
    int          stall_cyc [NUM_ROWS][BEATS];
    hd_pkg::hv_t exp_vec [NUM_ROWS];
    int          seed = 32'h2856_9e3c;
    int          value_errs = 0;
    int          proto_errs = 0;

    tb_clock clock_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN)
    );

    hd_top hd_top_i (
        .AXIS_ACLK (AXIS_ACLK), .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR (awaddr), .S_AXI_AWVALID (awvalid), .S_AXI_AWREADY (awready),
        .S_AXI_WDATA (wdata), .S_AXI_WSTRB (wstrb), .S_AXI_WVALID (wvalid),
        .S_AXI_WREADY (wready), .S_AXI_BRESP (bresp), .S_AXI_BVALID (bvalid),
        .S_AXI_BREADY (bready), .S_AXI_ARADDR (araddr), .S_AXI_ARVALID (arvalid),
        .S_AXI_ARREADY (arready), .S_AXI_RDATA (rdata), .S_AXI_RRESP (rresp),
        .S_AXI_RVALID (rvalid), .S_AXI_RREADY (rready), .M_AXIS_TVALID (tvalid),
        .M_AXIS_TDATA (tdata), .M_AXIS_TSTRB (tstrb), .M_AXIS_TLAST (tlast),
        .M_AXIS_TREADY (tready)
    );

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic hd_pkg::word_t xorshift_step(input hd_pkg::word_t s);
        hd_pkg::word_t a, b, c;
        a = s ^ (s << hd_pkg::XS_SHIFT_A);
        b = a ^ (a >> hd_pkg::XS_SHIFT_B);
        c = b ^ (b << hd_pkg::XS_SHIFT_C);
        return c;
    endfunction

    // words 4n..4n+3, word j into bits 32j+31:32j
    function automatic hd_pkg::hv_t model_vector(input int n);
        hd_pkg::word_t w;
        hd_pkg::hv_t   v;
        w = hd_pkg::XS_SEED;
        v = '0;
        for (int k = 0; k < 4 * n + 4; k++) begin
            w = xorshift_step(w);
            if (k >= 4 * n) v[(k - 4 * n) * 32 +: 32] = w;
        end
        return v;
    endfunction

    // ======================================================================
    // bus tasks, inputs change 1 ns after the edge, outputs seen at negedge
    // ======================================================================
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        int waited;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        @(negedge AXIS_ACLK);
        while (!(awready && wready) && waited < HS_LIMIT) begin
            @(negedge AXIS_ACLK);
            waited++;
        end
        if (waited >= HS_LIMIT) begin
            $display("write to 0x%h was never accepted", addr);
            proto_errs++;
        end
        @(posedge AXIS_ACLK);
        #(DRIVE_DLY);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        waited  = 0;
        @(negedge AXIS_ACLK);
        while (!bvalid && waited < HS_LIMIT) begin
            @(negedge AXIS_ACLK);
            waited++;
        end
        if (waited >= HS_LIMIT) begin
            $display("no write response for address 0x%h", addr);
            proto_errs++;
        end else if (bresp !== axi_lite_pkg::RESP_OKAY) begin
            $display("FAILED BRESP got 0x%h expected 0x%h", bresp, axi_lite_pkg::RESP_OKAY);
            value_errs++;
        end
        @(posedge AXIS_ACLK);
        #(DRIVE_DLY);
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        int waited;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        data    = 'x;
        @(negedge AXIS_ACLK);
        while (!arready && waited < HS_LIMIT) begin
            @(negedge AXIS_ACLK);
            waited++;
        end
        if (waited >= HS_LIMIT) begin
            $display("read of address 0x%h was never accepted", addr);
            proto_errs++;
        end
        @(posedge AXIS_ACLK);
        #(DRIVE_DLY);
        arvalid = 1'b0;
        rready  = 1'b1;
        waited  = 0;
        @(negedge AXIS_ACLK);
        while (!rvalid && waited < HS_LIMIT) begin
            @(negedge AXIS_ACLK);
            waited++;
        end
        if (waited >= HS_LIMIT) begin
            $display("read of address 0x%h got no response", addr);
            proto_errs++;
        end else begin
            data = rdata;
            if (rresp !== axi_lite_pkg::RESP_OKAY) begin
                $display("FAILED RRESP got 0x%h expected 0x%h", rresp, axi_lite_pkg::RESP_OKAY);
                value_errs++;
            end
        end
        @(posedge AXIS_ACLK);
        #(DRIVE_DLY);
        rready = 1'b0;
    endtask

    // stall, check the hold, then accept one beat
    task automatic receive_beat(input int r, input int b);
        int          waited;
        logic [63:0] held_data;
        logic        held_last;
        waited = 0;
        @(negedge AXIS_ACLK);
        while (!tvalid && waited < HS_LIMIT) begin
            @(negedge AXIS_ACLK);
            waited++;
        end
        if (waited >= HS_LIMIT) begin
            $display("TVALID never rose for beat %0d of row %0d", b, r);
            proto_errs++;
            return;
        end
        held_data = tdata;
        held_last = tlast;
        repeat (stall_cyc[r][b]) begin
            @(negedge AXIS_ACLK);
            if (tvalid !== 1'b1 || tdata !== held_data || tlast !== held_last) begin
                $display("FAILED TDATA hold got 0x%h expected 0x%h", tdata, held_data);
                value_errs++;
            end
        end
        @(posedge AXIS_ACLK);
        #(DRIVE_DLY);
        tready = 1'b1;
        @(negedge AXIS_ACLK);
        if (tdata !== exp_vec[r][b * 64 +: 64]) begin
            $display("FAILED TDATA got 0x%h expected 0x%h", tdata, exp_vec[r][b * 64 +: 64]);
            value_errs++;
        end
        if (tlast !== (b == BEATS - 1)) begin
            $display("FAILED TLAST got 0x%h expected 0x%h", tlast, (b == BEATS - 1));
            value_errs++;
        end
        if (tstrb !== 8'hff) begin
            $display("FAILED TSTRB got 0x%h expected 0x%h", tstrb, 8'hff);
            value_errs++;
        end
        @(posedge AXIS_ACLK);
        #(DRIVE_DLY);
        tready = 1'b0;
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin : main
        logic [31:0] rd;
        int          polls;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        tready = 1'b0;
        // fill the rest of the table
        for (int r = 0; r < NUM_ROWS; r++) begin
            exp_vec[r] = model_vector(row_n[r]);
            for (int b = 0; b < BEATS; b++) stall_cyc[r][b] = $random(seed) & 3;
        end
        wait (S_AXI_ARESETN === 1'b1);
        @(negedge AXIS_ACLK);
        // reset state of the outputs
        if ({bvalid, rvalid, tvalid, tlast} !== 4'b0000 || tdata !== '0) begin
            $display("FAILED reset outputs got 0x%h expected 0x0", {bvalid, rvalid, tvalid, tlast});
            value_errs++;
        end
        if (!(awready && wready)) begin
            $display("AWREADY and WREADY are not both high in idle");
            proto_errs++;
        end
        @(posedge AXIS_ACLK);
        #(DRIVE_DLY);
        read_reg(ADDR_CTRL, rd);
        if (rd !== 32'h0) begin
            $display("FAILED REG_CTRL got 0x%h expected 0x0", rd);
            value_errs++;
        end
        // decode, out-of-bank write must not land
        write_reg(ADDR_ITEM_NUM, 32'h0000_1234);
        write_reg(ADDR_OFF_BANK, 32'h0000_beef);
        read_reg(ADDR_EVEN, rd);
        if (rd !== 32'h0) begin
            $display("FAILED unmapped RDATA got 0x%h expected 0x0", rd);
            value_errs++;
        end
        read_reg(ADDR_ITEM_NUM, rd);
        if (rd !== 32'h0000_1234) begin
            $display("FAILED REG_ITEM_NUM got 0x%h expected 0x1234", rd);
            value_errs++;
        end
        // read register still holds 0x1234 here
        read_reg(ADDR_OFF_BANK, rd);
        if (rd !== 32'h0) begin
            $display("FAILED off-bank RDATA got 0x%h expected 0x0", rd);
            value_errs++;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            write_reg(ADDR_ITEM_NUM, row_n[r]);
            read_reg(ADDR_ITEM_NUM, rd);
            if (rd !== row_n[r]) begin
                $display("FAILED REG_ITEM_NUM got 0x%h expected 0x%h", rd, row_n[r]);
                value_errs++;
            end
            // gen, then poll for the self-clear
            // at most one poll per generation cycle
            write_reg(ADDR_CTRL, 32'h1);
            polls = 0;
            rd = 32'h1;
            while (rd[0] !== 1'b0 && polls < 4 * (row_n[r] + 1) + 20) begin
                read_reg(ADDR_CTRL, rd);
                polls++;
            end
            if (rd[0] !== 1'b0) begin
                $display("gen never cleared for item count %0d", row_n[r]);
                proto_errs++;
            end
            write_reg(ADDR_CTRL, 32'h2);
            for (int b = 0; b < BEATS; b++) receive_beat(r, b);
            // no extra beat after TLAST
            repeat (4) begin
                @(negedge AXIS_ACLK);
                if (tvalid !== 1'b0) begin
                    $display("FAILED TVALID after last beat got 0x%h expected 0x0", tvalid);
                    value_errs++;
                end
            end
            @(posedge AXIS_ACLK);
            #(DRIVE_DLY);
            read_reg(ADDR_CTRL, rd);
            if (rd !== 32'h0) begin
                $display("FAILED REG_CTRL got 0x%h expected 0x0", rd);
                value_errs++;
            end
        end
        $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // limit from the item counts in the table
    initial begin : watchdog
        int limit;
        limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) limit += 4 * (row_n[r] + 1) + 200;
        repeat (limit) @(posedge AXIS_ACLK);
        $display("watchdog expired after %0d cycles", limit);
        $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== sim.f ====
hw/axi_lite_pkg.sv
hw/hd_pkg.sv
hw/axi_lite_slave.sv
hw/ctrl_regs.sv
hw/xorshift32.sv
hw/item_memory_gen.sv
hw/stream_out.sv
hw/hd_top.sv
testbench/tb_clock.sv
testbench/tb_hd_top.sv
